/* sim.f */
+incdir+tests
src/trade_pkg.sv
src/ledger_pkg.sv
src/ledger_if.sv
src/order_intake.sv
src/cancel_ledger.sv
src/risk_check.sv
src/risk_gate_top.sv
tests/risk_gate_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the risk gate testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing -f sim.f --top-module risk_gate_tb -o risk_gate_sim \
  > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }

./obj_dir/risk_gate_sim > "$log" 2>&1 \
  || { echo "simulator exited with an error, see $log"; exit 1; }

grep -q "FAIL: see errors above" "$log" \
  && { echo "simulation failed, see $log"; exit 1; }

grep -q "PASS: all tests" "$log" \
  || { echo "simulation did not finish, see $log"; exit 1; }

echo "simulation passed"

/* tests/risk_gate_model.svh */
// Reference model for the risk gate testbench.
// Holds the model ledger, running sum and limit, the expected-result
// function for one order and the LFSR that feeds the random test.
// Included inside the testbench module, after its package imports.
`ifndef RISK_GATE_MODEL_SVH
`define RISK_GATE_MODEL_SVH

typedef struct packed {
  bit     accept;  // expected verdict
  limit_t sum;     // running sum after this order
  limit_t limit;   // limit the order is judged against
} expect_t;

cancel_total_t model_ledger [LEDGER_DEPTH_DEFAULT];
limit_t        model_sum;
limit_t        model_limit;
logic [15:0]   lfsr_state;

function automatic void model_reset();
  for (int i = 0; i < LEDGER_DEPTH_DEFAULT; i++)
    model_ledger[i] = '0;
  model_sum   = '0;
  model_limit = '0;
  lfsr_state  = 16'd99;  // seed
endfunction

// verdict for one order against the current model state and the sum it leaves
function automatic bit expected_order(input client_id_t client, input amount_t amount,
                                      output limit_t new_sum);
  longint cancelled;
  longint exposure;
  bit     accept;
  cancelled = 0;
  if (int'(client) < CLIENT_COUNT)
    cancelled = longint'(model_ledger[client]);  // unknown clients have no cancels
  exposure = longint'(model_sum) + longint'(amount) - cancelled;
  accept   = (exposure < longint'(model_limit));
  new_sum  = accept ? model_sum + limit_t'(amount) : model_sum;
  return accept;
endfunction

// one step of a 16-bit Galois LFSR with taps 16 14 13 11
function automatic bit galois_lfsr();
  bit out;
  out        = lfsr_state[0];
  lfsr_state = lfsr_state >> 1;
  if (out)
    lfsr_state = lfsr_state ^ 16'hB400;
  return out;
endfunction

function automatic int unsigned take_bits(input int n);
  int unsigned v;
  v = 0;
  for (int i = 0; i < n; i++)
    v = {v[30:0], galois_lfsr()};  // one step per bit
  return v;
endfunction

`endif

/* tests/risk_gate_tb.sv */
// Testbench for the pre-trade risk gate.
// Drives orders, limit loads and exchange cancels on the falling edge,
// predicts each verdict with the model in risk_gate_model.svh and checks
// every order_done against a queue of expected results.
`timescale 1ns/100ps

module risk_gate_tb;
  import trade_pkg::*;
  import ledger_pkg::*;

  localparam int CLIENT_COUNT    = LEDGER_DEPTH_DEFAULT;
  localparam int RESET_CYCLES    = 4;
  localparam int DIRECTED_CYCLES = 80;   // five directed tests with their drains
  localparam int RANDOM_CYCLES   = 300;
  localparam int DRAIN_LIMIT     = 8;    // cycles allowed for outstanding dones
  localparam int TIMEOUT_CYCLES  = RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES
                                   + DRAIN_LIMIT + 2 + 100;

  logic       clk = 1'b0;
  logic       arst_n;
  client_id_t cpu_client_id;
  amount_t    cpu_amount;
  logic       cpu_go;
  logic       cpu_new_max;
  limit_t     cpu_max;
  client_id_t exchange_client_id;
  amount_t    exchange_amount;
  logic       exchange_go;
  logic       order_done;
  logic       order_accept;
  limit_t     accumulated_orders;
  limit_t     max_to_trade;

  `include "risk_gate_model.svh"

  expect_t expected_q [$];
  expect_t head;
  int      error_count   = 0;
  int      checked_count = 0;
  int      test_errors   = 0;
  int      cycle_count   = 0;

  risk_gate_top #(
    .CLIENT_COUNT (CLIENT_COUNT)
  ) risk_gate_top_i (
    .clk                (clk),
    .arst_n             (arst_n),
    .cpu_client_id      (cpu_client_id),
    .cpu_amount         (cpu_amount),
    .cpu_go             (cpu_go),
    .cpu_new_max        (cpu_new_max),
    .cpu_max            (cpu_max),
    .exchange_client_id (exchange_client_id),
    .exchange_amount    (exchange_amount),
    .exchange_go        (exchange_go),
    .order_done         (order_done),
    .order_accept       (order_accept),
    .accumulated_orders (accumulated_orders),
    .max_to_trade       (max_to_trade)
  );

  always #4 clk = ~clk;  // 8 ns period

  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES)
    begin
      $display("run stopped after %0d cycles without finishing the tests", cycle_count);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // compare
  ////////////////////////////////////////////////////////////
  task automatic check_accept(input bit actual, input bit expected);
    if (actual !== expected)
    begin
      error_count++;
      $display("Error: order_accept is 0x%0h, expected 0x%0h", actual, expected);
    end
  endtask

  task automatic check_limit(input string name, input limit_t actual, input limit_t expected);
    if (actual !== expected)
    begin
      error_count++;
      $display("Error: %s is 0x%08h, expected 0x%08h", name, actual, expected);
    end
  endtask

  // registered outputs, sampled before the edge updates them
  always @(posedge clk)
  begin
    if (arst_n && order_done)
    begin
      if (expected_q.size() == 0)
      begin
        error_count++;
        $display("order_done pulsed while no order was outstanding");
      end
      else
      begin
        head = expected_q.pop_front();
        checked_count++;
        check_accept(order_accept, head.accept);
        check_limit("accumulated_orders", accumulated_orders, head.sum);
        check_limit("max_to_trade", max_to_trade, head.limit);
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////
  task automatic clear_strobes();
    cpu_go      = 1'b0;
    cpu_new_max = 1'b0;
    exchange_go = 1'b0;
  endtask

  task automatic send_order(input client_id_t client, input amount_t amount);
    expect_t e;
    limit_t  new_sum;
    @(negedge clk);
    clear_strobes();
    cpu_go        = 1'b1;
    cpu_client_id = client;
    cpu_amount    = amount;
    e.accept      = expected_order(client, amount, new_sum);
    e.sum         = new_sum;
    e.limit       = model_limit;
    model_sum     = new_sum;
    expected_q.push_back(e);
  endtask

  task automatic load_limit(input limit_t value);
    @(negedge clk);
    clear_strobes();
    cpu_new_max = 1'b1;
    cpu_max     = value;
    model_limit = value;
  endtask

  // both strobes together drop the order without a done
  task automatic load_limit_with_order(input limit_t value, input client_id_t client,
                                       input amount_t amount);
    @(negedge clk);
    clear_strobes();
    cpu_new_max   = 1'b1;
    cpu_max       = value;
    cpu_go        = 1'b1;
    cpu_client_id = client;
    cpu_amount    = amount;
    model_limit   = value;
  endtask

  task automatic apply_cancel(input client_id_t client, input amount_t amount);
    @(negedge clk);
    clear_strobes();
    exchange_go        = 1'b1;
    exchange_client_id = client;
    exchange_amount    = amount;
    if (int'(client) < CLIENT_COUNT)
      model_ledger[client] = model_ledger[client] + cancel_total_t'(amount);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n)
    begin
      @(negedge clk);
      clear_strobes();
    end
  endtask

  task automatic drain_orders();
    int waited;
    waited = 0;
    while (expected_q.size() != 0 && waited < DRAIN_LIMIT)
    begin
      @(negedge clk);
      clear_strobes();
      waited++;
    end
    if (expected_q.size() != 0)
    begin
      error_count++;
      $display("%0d orders never got a done pulse", expected_q.size());
      expected_q.delete();
    end
    idle_cycles(2);  // room for a stray done
  endtask

  task automatic report_test(input string name);
    drain_orders();
    if (error_count == test_errors)
      $display("test %s: ok", name);
    else
      $display("test %s: %0d errors", name, error_count - test_errors);
    test_errors = error_count;
  endtask

  ////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////
  task automatic orders_without_limit();
    send_order(5'd1, 16'd10);
    send_order(5'd1, 16'd0);  // 0 < 0 fails too
    send_order(5'd2, 16'd1);
    report_test("no limit loaded");
  endtask

  task automatic orders_up_to_limit();
    load_limit(32'd1000);
    repeat (4)
      send_order(5'd3, 16'd300);  // fourth one would reach 1200
    send_order(5'd3, 16'd99);      // 999 still below
    send_order(5'd3, 16'd1);       // 1000 is not strictly below
    report_test("limit reached");
  endtask

  task automatic cancel_allowance();
    load_limit(32'd1200);
    apply_cancel(5'd5, 16'd500);
    idle_cycles(1);
    send_order(5'd6, 16'd400);  // no cancels so it fails
    send_order(5'd5, 16'd400);  // same size passes on the cancel credit
    report_test("cancel allowance");
  endtask

  task automatic back_to_back_orders();
    load_limit(32'd5000);
    for (int i = 0; i < 5; i++)
      send_order(client_id_t'(8 + i), 16'd900);
    send_order(5'd13, 16'd0);
    report_test("back to back");
  endtask

  task automatic load_beats_order();
    load_limit_with_order(32'd6000, 5'd9, 16'd2000);
    send_order(5'd9, 16'd1000);
    send_order(5'd9, 16'd1);
    report_test("limit load wins");
  endtask

  task automatic random_mix();
    int unsigned kind;
    client_id_t  client;
    client_id_t  last_cancel;
    bit          cancel_last;
    cancel_last = 1'b0;
    last_cancel = '0;
    repeat (RANDOM_CYCLES)
    begin
      kind   = take_bits(3);
      client = client_id_t'(take_bits(5));
      if (kind < 4)
      begin
        if (cancel_last && client == last_cancel)
          idle_cycles(1);  // keep a gap after a cancel for this client
        else
          send_order(client, amount_t'(take_bits(16)));
        cancel_last = 1'b0;
      end
      else if (kind < 6)
      begin
        apply_cancel(client, amount_t'(take_bits(12)));
        cancel_last = 1'b1;
        last_cancel = client;
      end
      else if (kind == 6)
      begin
        load_limit(model_sum + limit_t'(take_bits(18)));  // headroom for a few orders
        cancel_last = 1'b0;
      end
      else
      begin
        idle_cycles(1);
        cancel_last = 1'b0;
      end
    end
    report_test("random mix");
  endtask

  initial
  begin
    cpu_client_id      = '0;
    cpu_amount         = '0;
    cpu_go             = 1'b0;
    cpu_new_max        = 1'b0;
    cpu_max            = '0;
    exchange_client_id = '0;
    exchange_amount    = '0;
    exchange_go        = 1'b0;
    arst_n             = 1'b0;
    model_reset();
    repeat (RESET_CYCLES) @(negedge clk);
    arst_n = 1'b1;

    orders_without_limit();
    orders_up_to_limit();
    cancel_allowance();
    back_to_back_orders();
    load_beats_order();
    random_mix();

    $display("orders checked: %0d, errors: %0d", checked_count, error_count);
    if (error_count == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

/* src/risk_gate_top.sv */
// Top level of the pre-trade risk gate.
// CPU orders and limit loads pass intake -> cancel ledger -> risk check,
// with a fixed latency of three cycles to order_done. Exchange cancels go
// straight into the ledger. CLIENT_COUNT sets the number of ledger entries.
`timescale 1ns/100ps

module risk_gate_top #(
  parameter int CLIENT_COUNT = ledger_pkg::LEDGER_DEPTH_DEFAULT
) (
  input  logic                  clk,
  input  logic                  arst_n,

  // cpu side
  input  trade_pkg::client_id_t cpu_client_id,
  input  trade_pkg::amount_t    cpu_amount,
  input  logic                  cpu_go,
  input  logic                  cpu_new_max,
  input  trade_pkg::limit_t     cpu_max,

  // exchange side
  input  trade_pkg::client_id_t exchange_client_id,
  input  trade_pkg::amount_t    exchange_amount,
  input  logic                  exchange_go,

  // verdict and status
  output logic                  order_done,
  output logic                  order_accept,
  output trade_pkg::limit_t     accumulated_orders,
  output trade_pkg::limit_t     max_to_trade
);

  ledger_if #(
    .CLIENT_COUNT (CLIENT_COUNT)
  ) lq_i ();

  ////////////////////////////////////////////////////////////
  // stages
  ////////////////////////////////////////////////////////////
  order_intake order_intake_i (
    .clk           (clk),
    .arst_n        (arst_n),
    .cpu_client_id (cpu_client_id),
    .cpu_amount    (cpu_amount),
    .cpu_go        (cpu_go),
    .cpu_new_max   (cpu_new_max),
    .cpu_max       (cpu_max),
    .lq            (lq_i)
  );

  cancel_ledger #(
    .CLIENT_COUNT (CLIENT_COUNT)
  ) cancel_ledger_i (
    .clk                (clk),
    .arst_n             (arst_n),
    .exchange_go        (exchange_go),
    .exchange_client_id (exchange_client_id),
    .exchange_amount    (exchange_amount),
    .lq                 (lq_i)
  );

  risk_check risk_check_i (
    .clk                (clk),
    .arst_n             (arst_n),
    .lq                 (lq_i),
    .order_done         (order_done),
    .order_accept       (order_accept),
    .accumulated_orders (accumulated_orders),
    .max_to_trade       (max_to_trade)
  );

endmodule

/* src/risk_check.sv */
// Risk check stage of the gate.
// Holds the trading limit and the running sum of accepted orders. An
// order passes when sum + amount - cancelled total is strictly below the
// limit, compared as signed values. Passing orders grow the sum, and every
// order gets a one-cycle done pulse with its verdict.
`timescale 1ns/100ps

module risk_check (
  input  logic              clk,
  input  logic              arst_n,
  ledger_if.check           lq,
  output logic              order_done,
  output logic              order_accept,
  output trade_pkg::limit_t accumulated_orders,
  output trade_pkg::limit_t max_to_trade
);
  import trade_pkg::*;
  import ledger_pkg::*;

  limit_t    limit_r;
  limit_t    sum_r;
  exposure_t exposure;
  logic      is_order;
  logic      is_set_max;
  logic      pass;
  logic      done_r;
  logic      accept_r;

  ////////////////////////////////////////////////////////////
  // verdict
  ////////////////////////////////////////////////////////////
  assign is_order   = (lq.op_q == op_order);
  assign is_set_max = (lq.op_q == op_set_max);

  // rd_data is this client's cancelled total, read one cycle earlier
  assign exposure = order_exposure(sum_r, lq.amount_q, lq.rd_data);
  assign pass     = (exposure < exposure_t'(limit_r));  // strict, signed

  ////////////////////////////////////////////////////////////
  // limit and running sum
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      limit_r <= '0;  // nothing trades until a limit arrives
    else if (is_set_max)
      limit_r <= lq.limit_value_q;
  end

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      sum_r <= '0;
    else if (is_order && pass)
      sum_r <= sum_r + limit_t'(lq.amount_q);  // wraps at 32 bits
  end

  ////////////////////////////////////////////////////////////
  // done and accept
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      done_r   <= 1'b0;
      accept_r <= 1'b0;
    end
    else
    begin
      done_r   <= is_order;
      accept_r <= is_order && pass;  // low outside the done cycle
    end
  end

  assign order_done         = done_r;
  assign order_accept       = accept_r;
  assign accumulated_orders = sum_r;
  assign max_to_trade       = limit_r;

endmodule

/* src/cancel_ledger.sv */
// Per-client cancel ledger of the risk gate.
// Each entry accumulates the amounts that the exchange reports as
// cancelled for one client. Reads are registered and see the entry as it
// was before a same-edge cancel. The operation from the intake is carried
// one stage so that it leaves together with the read data.
`timescale 1ns/100ps

module cancel_ledger #(
  parameter int CLIENT_COUNT = ledger_pkg::LEDGER_DEPTH_DEFAULT
) (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  exchange_go,
  input  trade_pkg::client_id_t exchange_client_id,
  input  trade_pkg::amount_t    exchange_amount,
  ledger_if.ledger              lq
);
  import trade_pkg::*;
  import ledger_pkg::*;

  cancel_total_t entries [CLIENT_COUNT];
  logic          cancel_hit;

  assign cancel_hit = exchange_go && (int'(exchange_client_id) < CLIENT_COUNT);

  ////////////////////////////////////////////////////////////
  // cancel accumulation
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      for (int i = 0; i < CLIENT_COUNT; i++)
        entries[i] <= '0;
    end
    else if (cancel_hit)
    begin
      entries[exchange_client_id] <= entries[exchange_client_id]
                                     + cancel_total_t'(exchange_amount);
    end
  end

  ////////////////////////////////////////////////////////////
  // read port and operation forwarding
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk)
  begin
    if (lq.rd_en)
      lq.rd_data <= lq.rd_hit ? entries[lq.rd_index] : '0;  // old value on collision
  end

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      lq.op_q <= op_none;
    else
      lq.op_q <= lq.op;
  end

  // payload alongside op_q
  always_ff @(posedge clk)
  begin
    lq.amount_q      <= lq.amount;
    lq.limit_value_q <= lq.limit_value;
  end

endmodule

/* src/order_intake.sv */
// Order intake stage of the risk gate.
// Folds the cpu_go and cpu_new_max strobes into one operation, with the
// limit load winning when both are high, and registers it together with
// the client, amount and new limit. Orders also start a ledger read.
`timescale 1ns/100ps

module order_intake (
  input  logic                  clk,
  input  logic                  arst_n,
  input  trade_pkg::client_id_t cpu_client_id,
  input  trade_pkg::amount_t    cpu_amount,
  input  logic                  cpu_go,
  input  logic                  cpu_new_max,
  input  trade_pkg::limit_t     cpu_max,
  ledger_if.intake              lq
);
  import trade_pkg::*;

  op_t        op_next;
  op_t        op_r;
  logic       rd_en_r;
  client_id_t client_r;
  amount_t    amount_r;
  limit_t     limit_r;

  ////////////////////////////////////////////////////////////
  // strobe decode
  ////////////////////////////////////////////////////////////
  always_comb
  begin
    if (cpu_new_max)
      op_next = op_set_max;  // a simultaneous order is dropped
    else if (cpu_go)
      op_next = op_order;
    else
      op_next = op_none;
  end

  ////////////////////////////////////////////////////////////
  // operation register
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      op_r    <= op_none;
      rd_en_r <= 1'b0;
    end
    else
    begin
      op_r    <= op_next;
      rd_en_r <= (op_next == op_order);  // only orders look at the ledger
    end
  end

  // payload follows the strobe that owns it
  always_ff @(posedge clk)
  begin
    if (op_next == op_order)
    begin
      client_r <= cpu_client_id;
      amount_r <= cpu_amount;
    end
    if (cpu_new_max)
      limit_r <= cpu_max;
  end

  assign lq.op          = op_r;
  assign lq.rd_en       = rd_en_r;
  assign lq.rd_index    = client_r;
  assign lq.amount      = amount_r;
  assign lq.limit_value = limit_r;

endmodule

/* src/ledger_if.sv */
// Ledger traffic between order intake, cancel ledger and risk check.
// The intake side issues the read and the operation; the ledger answers
// with the read data and a registered copy of the operation (the _q
// signals) so that the risk check sees data and operation aligned.
`timescale 1ns/100ps

interface ledger_if #(
  parameter int CLIENT_COUNT = ledger_pkg::LEDGER_DEPTH_DEFAULT
) ();
  import trade_pkg::*;
  import ledger_pkg::*;

  logic          rd_en;          // read the entry for rd_index
  client_id_t    rd_index;
  logic          rd_hit;         // rd_index names an existing entry
  cancel_total_t rd_data;        // valid the cycle after rd_en

  op_t           op;             // intake stage
  amount_t       amount;
  limit_t        limit_value;

  op_t           op_q;           // one stage later, beside rd_data
  amount_t       amount_q;
  limit_t        limit_value_q;

  assign rd_hit = (int'(rd_index) < CLIENT_COUNT);  // higher ids read as zero

  modport intake (output rd_en, rd_index, op, amount, limit_value);
  modport ledger (input rd_en, rd_index, rd_hit, op, amount, limit_value,
                  output rd_data, op_q, amount_q, limit_value_q);
  modport check  (input op_q, amount_q, limit_value_q, rd_data);

endinterface

/* src/ledger_pkg.sv */
// Types for the per-client cancel ledger and the exposure arithmetic.
// The exposure is evaluated in a signed width wide enough that the sum
// plus an amount minus a cancelled total never overflows.

package ledger_pkg;

  localparam int LEDGER_DEPTH_DEFAULT = 32;  // one entry per client number

  typedef logic [31:0]        cancel_total_t;  // accumulated cancels for one client
  typedef logic signed [33:0] exposure_t;      // sum + amount - cancelled

  // sum and cancelled are both 32-bit unsigned, so 34 signed bits hold
  // everything from -(2^32-1) up to (2^32-1) + (2^16-1)
  function automatic exposure_t order_exposure(
    input trade_pkg::limit_t  sum,
    input trade_pkg::amount_t amount,
    input cancel_total_t      cancelled
  );
    return exposure_t'(sum) + exposure_t'(amount) - exposure_t'(cancelled);
  endfunction

endpackage

/* src/trade_pkg.sv */
// Order-side types shared by the risk gate.
// Covers the CPU client number, order and cancel amounts, the limit and
// running-sum width, and the operation code that the intake produces.
// Import it inside a module body. Port lists use trade_pkg:: names.

package trade_pkg;

  ////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////
  localparam int CLIENT_ID_W = 5;   // up to 32 clients
  localparam int AMOUNT_W    = 16;
  localparam int LIMIT_W     = 32;  // running sum wraps at this width

  typedef logic [CLIENT_ID_W-1:0] client_id_t;
  typedef logic [AMOUNT_W-1:0]    amount_t;    // unsigned order or cancel size
  typedef logic [LIMIT_W-1:0]     limit_t;     // limit and accepted-order sum

  ////////////////////////////////////////////////////////////
  // intake operation
  ////////////////////////////////////////////////////////////
  typedef enum logic [1:0] {
    op_none    = 2'd0,  // idle cycle
    op_order   = 2'd1,  // judge an order
    op_set_max = 2'd2   // load a new trading limit
  } op_t;

endpackage
